// ==== verilog/axi_mem_config.svh ====
`ifndef AXI_MEM_CONFIG_SVH
`define AXI_MEM_CONFIG_SVH

// Byte address width on the AXI side.
`define AXI_ADDR_W 16
// AXI data width in bits.
`define AXI_DATA_W 64
// Transaction ID width.
`define AXI_ID_W 4

// Number of parallel banks, divides the data width.
`define NUM_BANKS 4
// Bank word width and its byte strobe width.
`define BANK_DATA_W (`AXI_DATA_W / `NUM_BANKS)
`define BANK_STRB_W (`BANK_DATA_W / 8)
// Bank word address, the AXI address without the byte offset.
`define BANK_ADDR_W (`AXI_ADDR_W - $clog2(`AXI_DATA_W / 8))

// Bank requests a lane may have waiting for a response.
`define MAX_TRANS 4
// Lane request queue and metadata queue depth.
`define FIFO_DEPTH 4

`endif

// ==== verilog/axi_mem_pkg.sv ====
`include "axi_mem_config.svh"

package axi_mem_pkg;

  typedef logic [`AXI_ADDR_W-1:0]   addr_t;
  typedef logic [`AXI_ID_W-1:0]     id_t;
  typedef logic [`AXI_DATA_W-1:0]   data_t;
  typedef logic [`AXI_DATA_W/8-1:0] strb_t;

  // Only OKAY and SLVERR are ever returned.
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // Address channel, INCR bursts only.
  typedef struct packed {
    id_t         id;
    addr_t       addr;
    logic [7:0]  len;
    logic [2:0]  size;
  } ar_chan_t;

  // Write address uses the same layout.
  typedef ar_chan_t aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    data_t data;
    id_t   id;
    resp_e resp;
    logic  last;
  } r_chan_t;

  typedef struct packed {
    id_t   id;
    resp_e resp;
  } b_chan_t;

  // One arbitrated beat, read or write.
  typedef struct packed {
    addr_t      addr;
    logic       write;
    logic       last;
    logic [2:0] size;
    id_t        id;
    strb_t      strb;
    data_t      wdata;
  } beat_t;

  // One bank's share of a beat.
  typedef struct packed {
    logic [`BANK_ADDR_W-1:0] addr;
    logic                    we;
    logic [`BANK_STRB_W-1:0] strb;
    logic [`BANK_DATA_W-1:0] wdata;
  } bank_req_t;

  typedef struct packed {
    logic [`BANK_DATA_W-1:0] rdata;
    logic                    err;
  } bank_rsp_t;

  // Beat without write data, kept until its responses return.
  typedef struct packed {
    addr_t      addr;
    logic       write;
    logic       last;
    logic [2:0] size;
    id_t        id;
    strb_t      strb;
  } meta_t;

endpackage

// ==== verilog/mem_fifo.sv ====
`timescale 1ns/1ps

module mem_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned depth     = 4
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o
);

  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  payload_t         mem_q [depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] fill_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (fill_q == cnt_w'(depth));
  assign empty_o = (fill_q == '0);

  // Pushes on full and pops on empty are ignored.
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Head entry, seen one cycle after its push.
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      // Pointers wrap at the last entry.
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      fill_q <= fill_q + cnt_w'(do_push) - cnt_w'(do_pop);
    end
  end

endmodule

// ==== verilog/axi_burst_sequencer.sv ====
`timescale 1ns/1ps
`include "axi_mem_config.svh"

module axi_burst_sequencer (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  input  axi_mem_pkg::ar_chan_t ar_i,
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  axi_mem_pkg::aw_chan_t aw_i,
  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  input  axi_mem_pkg::w_chan_t  w_i,
  output axi_mem_pkg::beat_t    beat_o,
  output logic                  beat_valid_o,
  input  logic                  beat_ready_i
);
  import axi_mem_pkg::*;

  // Burst state, len holds the beats still to go.
  ar_chan_t rd_q;
  ar_chan_t rd_d;
  aw_chan_t wr_q;
  aw_chan_t wr_d;
  // Side choice, 1 means write.
  logic     sel_q;
  logic     sel_d;
  logic     lock_q;
  logic     rd_valid;
  logic     wr_valid;
  logic     advance;
  beat_t    rd_beat;
  beat_t    wr_beat;

  // Next beat address, aligned to the size.
  function automatic addr_t step_addr(addr_t addr, logic [2:0] size);
    addr_t mask;
    mask = addr_t'((32'd1 << size) - 1);
    return (addr & ~mask) + addr_t'(32'd1 << size);
  endfunction

  always_comb begin
    rd_d    = rd_q;
    wr_d    = wr_q;
    rd_beat = '0;
    wr_beat = '0;

    // Read side, a burst in progress or a new AR.
    if (rd_q.len != '0) begin
      rd_valid     = 1'b1;
      rd_beat.addr = step_addr(rd_q.addr, rd_q.size);
      rd_beat.last = (rd_q.len == 8'd1);
      rd_beat.size = rd_q.size;
      rd_beat.id   = rd_q.id;
    end else begin
      rd_valid     = ar_valid_i;
      rd_beat.addr = ar_i.addr;
      rd_beat.last = (ar_i.len == '0);
      rd_beat.size = ar_i.size;
      rd_beat.id   = ar_i.id;
    end

    // Write side, a new AW needs its first W as well.
    if (wr_q.len != '0) begin
      wr_valid     = w_valid_i;
      wr_beat.addr = step_addr(wr_q.addr, wr_q.size);
      wr_beat.last = (wr_q.len == 8'd1);
      wr_beat.size = wr_q.size;
      wr_beat.id   = wr_q.id;
    end else begin
      wr_valid     = aw_valid_i & w_valid_i;
      wr_beat.addr = aw_i.addr;
      wr_beat.last = (aw_i.len == '0);
      wr_beat.size = aw_i.size;
      wr_beat.id   = aw_i.id;
    end
    wr_beat.write = 1'b1;
    wr_beat.strb  = w_i.strb;
    wr_beat.wdata = w_i.data;

    // Arbitration, held while a beat waits.
    sel_d = sel_q;
    if (!lock_q) begin
      if (wr_valid ^ rd_valid) begin
        sel_d = wr_valid;
      end else if (wr_valid && rd_valid) begin
        // Single writes first, then open bursts, then alternate.
        if (wr_beat.last && !rd_beat.last) begin
          sel_d = 1'b1;
        end else if (wr_q.len != '0) begin
          sel_d = 1'b1;
        end else if (rd_q.len != '0) begin
          sel_d = 1'b0;
        end else begin
          sel_d = ~sel_q;
        end
      end
    end

    beat_o       = sel_d ? wr_beat : rd_beat;
    beat_valid_o = sel_d ? wr_valid : rd_valid;
    advance      = beat_valid_o & beat_ready_i;

    // Address channels are taken with their first beat.
    ar_ready_o = advance & ~sel_d & (rd_q.len == '0);
    aw_ready_o = advance & sel_d & (wr_q.len == '0);
    w_ready_o  = advance & sel_d;

    if (advance && !sel_d) begin
      if (rd_q.len == '0) begin
        rd_d = ar_i;
      end else begin
        rd_d.len  = rd_q.len - 8'd1;
        rd_d.addr = rd_beat.addr;
      end
    end
    if (advance && sel_d) begin
      if (wr_q.len == '0) begin
        wr_d = aw_i;
      end else begin
        wr_d.len  = wr_q.len - 8'd1;
        wr_d.addr = wr_beat.addr;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_q   <= '0;
      wr_q   <= '0;
      sel_q  <= 1'b0;
      lock_q <= 1'b0;
    end else begin
      rd_q   <= rd_d;
      wr_q   <= wr_d;
      sel_q  <= sel_d;
      lock_q <= beat_valid_o & ~beat_ready_i;
    end
  end

endmodule

// ==== verilog/bank_lane.sv ====
`timescale 1ns/1ps
`include "axi_mem_config.svh"

module bank_lane #(
  parameter int unsigned bank_idx = 0
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  axi_mem_pkg::beat_t     beat_i,
  input  logic                   push_i,
  output logic                   ready_o,
  output axi_mem_pkg::bank_req_t bank_req_o,
  output logic                   req_o,
  input  logic                   gnt_i,
  input  logic                   rvalid_i,
  input  axi_mem_pkg::bank_rsp_t rsp_i,
  output axi_mem_pkg::bank_rsp_t rsp_o,
  output logic                   rsp_valid_o,
  input  logic                   rsp_pop_i
);
  import axi_mem_pkg::*;

  localparam int unsigned cnt_w    = $clog2(`MAX_TRANS + 1);
  localparam int unsigned word_lsb = $clog2(`AXI_DATA_W / 8);

  bank_req_t        req_in;
  logic             req_full;
  logic             req_empty;
  logic             rsp_empty;
  logic             issue;
  // Granted requests whose response is not popped yet.
  logic [cnt_w-1:0] credit_q;

  // This bank's slice of the beat.
  always_comb begin
    req_in.addr  = beat_i.addr[`AXI_ADDR_W-1:word_lsb];
    req_in.we    = beat_i.write;
    req_in.strb  = beat_i.strb[bank_idx*`BANK_STRB_W +: `BANK_STRB_W];
    req_in.wdata = beat_i.wdata[bank_idx*`BANK_DATA_W +: `BANK_DATA_W];
  end

  assign ready_o = ~req_full;

  mem_fifo #(
    .payload_t(bank_req_t),
    .depth    (`FIFO_DEPTH)
  ) req_fifo_i (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .push_i (push_i),
    .data_i (req_in),
    .full_o (req_full),
    .pop_i  (issue),
    .data_o (bank_req_o),
    .empty_o(req_empty)
  );

  // Issue only with room left in the response buffer.
  // Credit only moves on a grant, so a raised req holds.
  assign req_o = ~req_empty & (credit_q < cnt_w'(`MAX_TRANS));
  assign issue = req_o & gnt_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_q <= '0;
    end else begin
      credit_q <= credit_q + cnt_w'(issue) - cnt_w'(rsp_pop_i);
    end
  end

  // In-order responses wait here for the merger.
  mem_fifo #(
    .payload_t(bank_rsp_t),
    .depth    (`MAX_TRANS)
  ) rsp_fifo_i (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .push_i (rvalid_i),
    .data_i (rsp_i),
    .full_o (),
    .pop_i  (rsp_pop_i),
    .data_o (rsp_o),
    .empty_o(rsp_empty)
  );

  assign rsp_valid_o = ~rsp_empty;

endmodule

// ==== verilog/resp_merger.sv ====
`timescale 1ns/1ps
`include "axi_mem_config.svh"

module resp_merger (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  axi_mem_pkg::beat_t                     beat_i,
  input  logic                                   push_i,
  output logic                                   ready_o,
  input  axi_mem_pkg::bank_rsp_t [`NUM_BANKS-1:0] lane_rsp_i,
  input  logic                   [`NUM_BANKS-1:0] lane_valid_i,
  output logic                                   rsp_pop_o,
  output axi_mem_pkg::r_chan_t                   r_o,
  output logic                                   r_valid_o,
  input  logic                                   r_ready_i,
  output axi_mem_pkg::b_chan_t                   b_o,
  output logic                                   b_valid_o,
  input  logic                                   b_ready_i
);
  import axi_mem_pkg::*;

  localparam int unsigned off_w = $clog2(`AXI_DATA_W / 8);

  meta_t                 meta_in;
  meta_t                 meta_q;
  logic                  meta_full;
  logic                  meta_empty;
  logic                  joined;
  logic                  beat_err;
  // Errors of the earlier beats of the open write burst.
  logic                  b_err_q;
  logic [`NUM_BANKS-1:0] used;
  logic [`NUM_BANKS-1:0] err_vec;

  always_comb begin
    meta_in.addr  = beat_i.addr;
    meta_in.write = beat_i.write;
    meta_in.last  = beat_i.last;
    meta_in.size  = beat_i.size;
    meta_in.id    = beat_i.id;
    meta_in.strb  = beat_i.strb;
  end

  mem_fifo #(
    .payload_t(meta_t),
    .depth    (`FIFO_DEPTH)
  ) meta_fifo_i (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .push_i (push_i),
    .data_i (meta_in),
    .full_o (meta_full),
    .pop_i  (rsp_pop_o),
    .data_o (meta_q),
    .empty_o(meta_empty)
  );

  assign ready_o = ~meta_full;
  // A beat is complete once every lane has answered it.
  assign joined  = ~meta_empty & (&lane_valid_i);

  always_comb begin
    int unsigned lo;
    int unsigned hi;
    // Byte range of a read beat within the data word.
    lo = 32'(meta_q.addr[off_w-1:0]);
    hi = lo + (32'd1 << meta_q.size);
    for (int unsigned i = 0; i < `NUM_BANKS; i++) begin
      // Writes use strobed banks, reads the banks the range overlaps.
      if (meta_q.write) begin
        used[i] = |meta_q.strb[i*`BANK_STRB_W +: `BANK_STRB_W];
      end else begin
        used[i] = (i * `BANK_STRB_W + `BANK_STRB_W > lo) && (i * `BANK_STRB_W < hi);
      end
      err_vec[i] = lane_rsp_i[i].err;
      r_o.data[i*`BANK_DATA_W +: `BANK_DATA_W] = lane_rsp_i[i].rdata;
    end
    beat_err = |(err_vec & used);
    r_o.id   = meta_q.id;
    r_o.last = meta_q.last;
    r_o.resp = beat_err ? RESP_SLVERR : RESP_OKAY;
  end

  // Single B carries the OR of all beats of the burst.
  assign b_o.id   = meta_q.id;
  assign b_o.resp = (b_err_q | beat_err) ? RESP_SLVERR : RESP_OKAY;

  always_comb begin
    r_valid_o = joined & ~meta_q.write;
    b_valid_o = joined & meta_q.write & meta_q.last;
    // Inner write beats leave without an AXI transfer.
    if (meta_q.write) begin
      rsp_pop_o = joined & (~meta_q.last | b_ready_i);
    end else begin
      rsp_pop_o = joined & r_ready_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      b_err_q <= 1'b0;
    end else if (rsp_pop_o && meta_q.write) begin
      b_err_q <= meta_q.last ? 1'b0 : (b_err_q | beat_err);
    end
  end

endmodule

// ==== verilog/axi_to_banked_mem.sv ====
`timescale 1ns/1ps
`include "axi_mem_config.svh"

module axi_to_banked_mem (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   ar_valid_i,
  output logic                                   ar_ready_o,
  input  axi_mem_pkg::ar_chan_t                  ar_i,
  input  logic                                   aw_valid_i,
  output logic                                   aw_ready_o,
  input  axi_mem_pkg::aw_chan_t                  aw_i,
  input  logic                                   w_valid_i,
  output logic                                   w_ready_o,
  input  axi_mem_pkg::w_chan_t                   w_i,
  output logic                                   r_valid_o,
  input  logic                                   r_ready_i,
  output axi_mem_pkg::r_chan_t                   r_o,
  output logic                                   b_valid_o,
  input  logic                                   b_ready_i,
  output axi_mem_pkg::b_chan_t                   b_o,
  output logic                   [`NUM_BANKS-1:0] bank_req_o,
  input  logic                   [`NUM_BANKS-1:0] bank_gnt_i,
  output axi_mem_pkg::bank_req_t [`NUM_BANKS-1:0] bank_o,
  input  logic                   [`NUM_BANKS-1:0] bank_rvalid_i,
  input  axi_mem_pkg::bank_rsp_t [`NUM_BANKS-1:0] bank_rsp_i
);
  import axi_mem_pkg::*;

  beat_t                      beat;
  logic                       beat_valid;
  logic                       beat_ready;
  logic                       beat_push;
  logic                       merge_ready;
  logic                       rsp_pop;
  logic      [`NUM_BANKS-1:0] lane_ready;
  logic      [`NUM_BANKS-1:0] lane_valid;
  bank_rsp_t [`NUM_BANKS-1:0] lane_rsp;

  // A beat moves only when every lane and the merger take it.
  assign beat_ready = (&lane_ready) & merge_ready;
  assign beat_push  = beat_valid & beat_ready;

  axi_burst_sequencer axi_burst_sequencer_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ar_valid_i  (ar_valid_i),
    .ar_ready_o  (ar_ready_o),
    .ar_i        (ar_i),
    .aw_valid_i  (aw_valid_i),
    .aw_ready_o  (aw_ready_o),
    .aw_i        (aw_i),
    .w_valid_i   (w_valid_i),
    .w_ready_o   (w_ready_o),
    .w_i         (w_i),
    .beat_o      (beat),
    .beat_valid_o(beat_valid),
    .beat_ready_i(beat_ready)
  );

  // One lane per bank, each sees the whole beat.
  for (genvar g = 0; g < `NUM_BANKS; g++) begin : gen_lane
    bank_lane #(
      .bank_idx(g)
    ) bank_lane_i (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .beat_i     (beat),
      .push_i     (beat_push),
      .ready_o    (lane_ready[g]),
      .bank_req_o (bank_o[g]),
      .req_o      (bank_req_o[g]),
      .gnt_i      (bank_gnt_i[g]),
      .rvalid_i   (bank_rvalid_i[g]),
      .rsp_i      (bank_rsp_i[g]),
      .rsp_o      (lane_rsp[g]),
      .rsp_valid_o(lane_valid[g]),
      .rsp_pop_i  (rsp_pop)
    );
  end

  resp_merger resp_merger_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .beat_i      (beat),
    .push_i      (beat_push),
    .ready_o     (merge_ready),
    .lane_rsp_i  (lane_rsp),
    .lane_valid_i(lane_valid),
    .rsp_pop_o   (rsp_pop),
    .r_o         (r_o),
    .r_valid_o   (r_valid_o),
    .r_ready_i   (r_ready_i),
    .b_o         (b_o),
    .b_valid_o   (b_valid_o),
    .b_ready_i   (b_ready_i)
  );

endmodule

// ==== dv/axi_to_banked_mem_assert.sv ====
`timescale 1ns/1ps
`include "axi_mem_config.svh"

module axi_to_banked_mem_assert (
  input logic                                   clk_i,
  input logic                                   rst_n_i,
  input logic                                   ar_valid_i,
  input logic                                   ar_ready_o,
  input axi_mem_pkg::ar_chan_t                  ar_i,
  input logic                                   aw_valid_i,
  input logic                                   aw_ready_o,
  input axi_mem_pkg::aw_chan_t                  aw_i,
  input logic                                   w_valid_i,
  input logic                                   w_ready_o,
  input axi_mem_pkg::w_chan_t                   w_i,
  input logic                                   r_valid_o,
  input logic                                   r_ready_i,
  input axi_mem_pkg::r_chan_t                   r_o,
  input logic                                   b_valid_o,
  input logic                                   b_ready_i,
  input axi_mem_pkg::b_chan_t                   b_o,
  input logic                   [`NUM_BANKS-1:0] bank_req_o,
  input logic                   [`NUM_BANKS-1:0] bank_gnt_i,
  input axi_mem_pkg::bank_req_t [`NUM_BANKS-1:0] bank_o
);
  import axi_mem_pkg::*;

  // Master side payloads hold while they wait for ready.
  a_ar_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ar_valid_i && !ar_ready_o |=> $stable(ar_i))
    else $error("AR payload changed while waiting for ready.");
  a_aw_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    aw_valid_i && !aw_ready_o |=> $stable(aw_i))
    else $error("AW payload changed while waiting for ready.");
  a_w_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    w_valid_i && !w_ready_o |=> $stable(w_i))
    else $error("W payload changed while waiting for ready.");

  // Slave side keeps valid and payload until taken.
  a_r_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o))
    else $error("R beat dropped or changed under back-pressure.");
  a_b_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_o))
    else $error("B response dropped or changed under back-pressure.");

  // Bank request holds until granted.
  for (genvar i = 0; i < `NUM_BANKS; i++) begin : gen_bank_chk
    a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      bank_req_o[i] && !bank_gnt_i[i] |=> bank_req_o[i] && $stable(bank_o[i]))
      else $error("Bank request withdrawn or changed before grant.");
  end

endmodule

bind axi_to_banked_mem axi_to_banked_mem_assert axi_to_banked_mem_assert_i (.*);

// ==== dv/tb_axi_to_banked_mem.sv ====
`timescale 1ns/1ps
`include "axi_mem_config.svh"

module tb_axi_to_banked_mem;
  import axi_mem_pkg::*;

  localparam int n_trans        = 120;
  // Sixteen beats per transaction, twenty cycles per beat at worst.
  localparam int timeout_cycles = n_trans * 16 * 20;

  logic clk_i;
  logic rst_n_i;
  logic ar_valid_i, ar_ready_o, aw_valid_i, aw_ready_o, w_valid_i, w_ready_o;
  logic r_valid_o, r_ready_i, b_valid_o, b_ready_i;
  ar_chan_t ar_i;
  aw_chan_t aw_i;
  w_chan_t  w_i;
  r_chan_t  r_o;
  b_chan_t  b_o;
  logic      [`NUM_BANKS-1:0] bank_req_o, bank_gnt_i, bank_rvalid_i;
  bank_req_t [`NUM_BANKS-1:0] bank_o;
  bank_rsp_t [`NUM_BANKS-1:0] bank_rsp_i;

  // Bank storage and the byte-level reference.
  logic [15:0] bank_mem [`NUM_BANKS][8192];
  logic [7:0]  ref_mem [65536];
  bank_rsp_t   rsp_q [`NUM_BANKS][$];
  int unsigned due_q [`NUM_BANKS][$];
  int unsigned last_due [`NUM_BANKS];
  int unsigned cyc;
  r_chan_t     exp_r [$];
  b_chan_t     exp_b [$];
  int          errors;
  int          checks;
  bit          stall_on;
  string       test_name;

  axi_to_banked_mem axi_to_banked_mem_i (.*);

  always #50 clk_i = ~clk_i;

  // Fill value spreads the whole word address and the bank.
  function automatic logic [15:0] init_word(int bank, int waddr);
    return 16'(waddr * 32'h2f1d + bank * 32'h4e35);
  endfunction

  // AXI INCR rule, later beats step from the aligned start.
  function automatic logic [15:0] beat_addr(logic [15:0] addr, int size, int b);
    logic [15:0] al;
    al = addr & ~16'((1 << size) - 1);
    if (b == 0) begin
      return addr;
    end else begin
      return al + 16'(b << size);
    end
  endfunction

  // Word address bits 11:8 all ones on bank 2.
  function automatic bit poison(logic [15:0] a);
    return a[14:11] == 4'hf;
  endfunction

  // Byte lanes a narrow beat occupies within the data word.
  function automatic logic [7:0] byte_lanes(logic [15:0] a, int size);
    return 8'(((1 << (1 << size)) - 1) << a[2:0]);
  endfunction

  task automatic check(string field, logic [63:0] exp, logic [63:0] act);
    checks++;
    if (exp !== act) begin
      $display("FAIL %s %s expected %h actual %h", test_name, field, exp, act);
      errors++;
    end
  endtask

  task automatic read_burst(logic [3:0] id, logic [15:0] addr, int len, int size);
    r_chan_t     e;
    logic [15:0] a;
    for (int b = 0; b <= len; b++) begin
      a = beat_addr(addr, size, b);
      for (int j = 0; j < 8; j++) begin
        e.data[8*j +: 8] = ref_mem[{a[15:3], 3'(j)}];
      end
      e.id   = id;
      e.last = (b == len);
      // Bank 2 serves bytes 4 and 5 of the word.
      e.resp = (|(byte_lanes(a, size) & 8'h30) && poison(a)) ? RESP_SLVERR : RESP_OKAY;
      exp_r.push_back(e);
    end
    @(negedge clk_i);
    ar_valid_i = 1'b1;
    ar_i.id    = id;
    ar_i.addr  = addr;
    ar_i.len   = 8'(len);
    ar_i.size  = 3'(size);
    do @(posedge clk_i); while (!ar_ready_o);
    @(negedge clk_i);
    ar_valid_i = 1'b0;
  endtask

  task automatic write_burst(logic [3:0] id, logic [15:0] addr, int len, int size, bit full);
    logic [15:0] a;
    logic [63:0] d;
    logic [7:0]  s;
    logic [7:0]  lanes;
    bit          err;
    b_chan_t     e;
    err = 1'b0;
    for (int b = 0; b <= len; b++) begin
      a     = beat_addr(addr, size, b);
      lanes = byte_lanes(a, size);
      d     = {$urandom, $urandom};
      s     = full ? lanes : (8'($urandom) & lanes);
      // Reference merges only strobed bytes.
      for (int j = 0; j < 8; j++) begin
        if (s[j]) begin
          ref_mem[{a[15:3], 3'(j)}] = d[8*j +: 8];
        end
      end
      if (|s[5:4] && poison(a)) begin
        err = 1'b1;
      end
      @(negedge clk_i);
      aw_valid_i = (b == 0);
      aw_i.id    = id;
      aw_i.addr  = addr;
      aw_i.len   = 8'(len);
      aw_i.size  = 3'(size);
      w_valid_i  = 1'b1;
      w_i.data   = d;
      w_i.strb   = s;
      w_i.last   = (b == len);
      do @(posedge clk_i); while (!w_ready_o);
      // AW goes in the same cycle as the first W beat.
      if (b == 0) begin
        check("aw_ready", 64'd1, 64'(aw_ready_o));
      end
    end
    e.id   = id;
    e.resp = err ? RESP_SLVERR : RESP_OKAY;
    exp_b.push_back(e);
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_r.size() != 0 || exp_b.size() != 0) begin
      @(posedge clk_i);
    end
  endtask

  // Bank model. Grants are sampled here and answered later in order.
  always @(posedge clk_i) begin
    bank_rsp_t   rsp;
    int unsigned due;
    cyc = cyc + 1;
    for (int i = 0; i < `NUM_BANKS; i++) begin
      if (rst_n_i && bank_req_o[i] && bank_gnt_i[i]) begin
        rsp.rdata = bank_mem[i][bank_o[i].addr];
        rsp.err   = (i == 2) && (bank_o[i].addr[11:8] == 4'hf);
        if (bank_o[i].we) begin
          for (int k = 0; k < 2; k++) begin
            if (bank_o[i].strb[k]) begin
              bank_mem[i][bank_o[i].addr][8*k +: 8] = bank_o[i].wdata[8*k +: 8];
            end
          end
        end
        due = cyc + $urandom_range(1, 4);
        if (due <= last_due[i]) begin
          due = last_due[i] + 1;
        end
        last_due[i] = due;
        rsp_q[i].push_back(rsp);
        due_q[i].push_back(due);
      end
    end
  end

  always @(negedge clk_i) begin
    for (int i = 0; i < `NUM_BANKS; i++) begin
      bank_gnt_i[i] = rst_n_i && ($urandom_range(0, 2) != 0);
      if (due_q[i].size() != 0 && due_q[i][0] <= cyc) begin
        bank_rvalid_i[i] = 1'b1;
        bank_rsp_i[i]    = rsp_q[i].pop_front();
        void'(due_q[i].pop_front());
      end else begin
        bank_rvalid_i[i] = 1'b0;
      end
    end
    // Random output stalls only while enabled.
    r_ready_i = stall_on ? ($urandom_range(0, 3) != 0) : 1'b1;
    b_ready_i = stall_on ? ($urandom_range(0, 3) != 0) : 1'b1;
  end

  // R and B monitors, in-order against the expected queues.
  always @(posedge clk_i) begin
    r_chan_t er;
    b_chan_t eb;
    if (rst_n_i && r_valid_o && r_ready_i) begin
      if (exp_r.size() == 0) begin
        $display("Error: R beat arrived with no read beat outstanding in %s", test_name);
        errors++;
      end else begin
        er = exp_r.pop_front();
        check("r_data", er.data, r_o.data);
        check("r_id", 64'(er.id), 64'(r_o.id));
        check("r_resp", 64'(er.resp), 64'(r_o.resp));
        check("r_last", 64'(er.last), 64'(r_o.last));
      end
    end
    if (rst_n_i && b_valid_o && b_ready_i) begin
      if (exp_b.size() == 0) begin
        $display("Error: B response arrived with no write outstanding in %s", test_name);
        errors++;
      end else begin
        eb = exp_b.pop_front();
        check("b_id", 64'(eb.id), 64'(b_o.id));
        check("b_resp", 64'(eb.resp), 64'(b_o.resp));
      end
    end
  end

  initial begin
    wait (cyc >= timeout_cycles);
    $display("Timeout after %0d cycles with transactions still open", cyc);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    logic [15:0] addr;
    logic [15:0] raddr;
    logic [15:0] waddr;
    logic [15:0] saved [8];
    logic [15:0] fill;
    logic [3:0]  id;
    int          len;
    int          size;
    int          rsize;
    void'($urandom(32'h0ed5_c310));
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    {ar_valid_i, aw_valid_i, w_valid_i, r_ready_i, b_ready_i} = '0;
    ar_i = '0;
    aw_i = '0;
    w_i = '0;
    bank_gnt_i = '0;
    bank_rvalid_i = '0;
    bank_rsp_i = '0;
    cyc = 0;
    errors = 0;
    checks = 0;
    stall_on = 1'b0;
    for (int b = 0; b < `NUM_BANKS; b++) begin
      last_due[b] = 0;
      for (int w = 0; w < 8192; w++) begin
        bank_mem[b][w] = init_word(b, w);
      end
    end
    for (int a = 0; a < 65536; a++) begin
      fill       = init_word((a >> 1) & 3, a >> 3);
      ref_mem[a] = a[0] ? fill[15:8] : fill[7:0];
    end
    repeat (10) @(negedge clk_i);
    rst_n_i = 1'b1;

    test_name = "single_rw";
    for (int k = 0; k < 8; k++) begin
      saved[k] = 16'($urandom_range(0, 16'h6fff)) & ~16'h7;
      write_burst(4'(k), saved[k], 0, 3, 1'b1);
    end
    wait_idle();
    for (int k = 0; k < 8; k++) begin
      read_burst(4'(k), saved[k], 0, 3);
    end
    wait_idle();

    test_name = "incr_read";
    for (int k = 0; k < 20; k++) begin
      size = $urandom_range(0, 3);
      addr = 16'($urandom_range(0, 16'h7000)) & ~16'((1 << size) - 1);
      read_burst(4'($urandom), addr, $urandom_range(0, 15), size);
    end
    wait_idle();

    test_name = "strobe_write";
    for (int k = 0; k < 10; k++) begin
      addr = 16'($urandom_range(0, 16'h6f00)) & ~16'h7;
      len  = $urandom_range(0, 7);
      id   = 4'($urandom);
      write_burst(id, addr, len, 3, 1'b0);
      wait_idle();
      read_burst(id, addr, len, 3);
      wait_idle();
    end

    // Reads in the low half, writes in the high half.
    test_name = "interleave";
    stall_on = 1'b1;
    fork
      begin
        for (int k = 0; k < 20; k++) begin
          rsize = $urandom_range(0, 3);
          raddr = 16'($urandom_range(0, 16'h7000)) & ~16'((1 << rsize) - 1);
          read_burst(4'($urandom), raddr, $urandom_range(0, 15), rsize);
        end
      end
      begin
        for (int k = 0; k < 20; k++) begin
          waddr = 16'($urandom_range(16'h8000, 16'hf000)) & ~16'h7;
          write_burst(4'($urandom), waddr, $urandom_range(0, 15), 3, 1'b0);
        end
      end
    join
    wait_idle();
    stall_on = 1'b0;

    test_name = "poison";
    for (int k = 0; k < 12; k++) begin
      size = $urandom_range(0, 3);
      addr = 16'($urandom_range(16'h7800, 16'h7fe0)) & ~16'((1 << size) - 1);
      id   = 4'($urandom);
      write_burst(id, addr, $urandom_range(0, 1), size, 1'b0);
      wait_idle();
      read_burst(id, addr, 0, size);
      wait_idle();
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/axi_mem_pkg.sv
verilog/mem_fifo.sv
verilog/axi_burst_sequencer.sv
verilog/bank_lane.sv
verilog/resp_merger.sv
verilog/axi_to_banked_mem.sv
dv/axi_to_banked_mem_assert.sv
dv/tb_axi_to_banked_mem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the testbench with Verilator, then check the log.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module tb_axi_to_banked_mem \
  -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
  exit 0
fi
exit 1
